//--- logic/nvme_wr_pkg.sv
`default_nettype none

package nvme_wr_pkg;

  // queue geometry, one command per slot
  localparam int QUEUE_DEPTH = 16;
  localparam int QIDX_W = $clog2(QUEUE_DEPTH);

  localparam int HOST_ADDR_W = 48;
  localparam int HOST_DATA_W = 128;
  localparam int MEM_ADDR_W = 32;
  // 16 entries of 64 B
  localparam int SQ_ADDR_W = 10;

  localparam int SQ_ENTRY_SHIFT = 6;
  localparam int CQ_ENTRY_SHIFT = 4;
  // 4 KiB buffer slot, also one logical block
  localparam int BUF_SLOT_SHIFT = 12;

  // write buffer window on the NVMe side
  localparam logic [MEM_ADDR_W-1:0] WRITE_BUF_BASE = MEM_ADDR_W'(516 * 1024 * 1024);

  // doorbells of I/O queue 1
  localparam logic [MEM_ADDR_W-1:0] SQ_TAIL_DB_ADDR = MEM_ADDR_W'('h1008);
  localparam logic [MEM_ADDR_W-1:0] CQ_HEAD_DB_ADDR = MEM_ADDR_W'('h100c);
  localparam logic [31:0] NSID_DEFAULT = 32'd1;

  localparam logic [1:0] AXI_BURST_INCR = 2'b01;
  // doorbell registers are 4 B wide
  localparam logic [2:0] DB_XFER_SIZE = 3'd2;

  typedef enum logic [7:0] {
    NVME_OP_WRITE = 8'h01
  } nvme_opcode_t;

  typedef enum logic [1:0] {
    CQ_IDLE,
    CQ_READ_ADDR,
    CQ_READ_DATA,
    CQ_RING_DB
  } cq_poll_state_t;

  typedef struct packed {
    logic [HOST_ADDR_W-1:0] addr;
    logic [7:0]             len;
    logic [2:0]             size;
    logic [1:0]             burst;
  } axi_addr_t;

  // submission queue entry, CDW0 in the low bits
  typedef struct packed {
    logic [31:0]  cdw15;
    logic [31:0]  cdw14;
    logic [31:0]  cdw13;
    logic [31:0]  cdw12;
    logic [63:0]  slba;
    logic [127:0] dptr;
    logic [63:0]  mptr;
    logic [63:0]  rsvd23;
    logic [31:0]  nsid;
    logic [15:0]  cid;
    logic [1:0]   psdt;
    logic [3:0]   rsvd0;
    logic [1:0]   fuse;
    nvme_opcode_t opcode;
  } sq_entry_t;

  typedef struct packed {
    logic [14:0] status;
    logic        phase;
    logic [15:0] cid;
    logic [15:0] sq_id;
    logic [15:0] sq_head;
    logic [31:0] dw1;
    logic [31:0] dw0;
  } cq_entry_t;

endpackage

`default_nettype wire

//--- logic/nvme_sq_submit.sv
`timescale 1ns/10ps
`default_nettype none

module nvme_sq_submit (
  input  logic                                clk,
  input  logic                                rstn,
  input  nvme_wr_pkg::axi_addr_t              host_aw,
  input  logic                                host_awvalid,
  output logic                                host_awready,
  output nvme_wr_pkg::axi_addr_t              sq_aw,
  output logic                                sq_awvalid,
  input  logic                                sq_awready,
  output nvme_wr_pkg::sq_entry_t              sq_w,
  output logic                                sq_wvalid,
  input  logic                                sq_wready,
  output nvme_wr_pkg::axi_addr_t              buf_aw,
  output logic                                buf_awvalid,
  input  logic                                buf_awready,
  input  logic [nvme_wr_pkg::QIDX_W-1:0]      sq_head,
  input  logic [nvme_wr_pkg::QUEUE_DEPTH-1:0] cid_state
);
  import nvme_wr_pkg::*;

  logic [QIDX_W-1:0]     sq_tail;
  logic [QIDX_W-1:0]     tail_next;
  logic                  cid_phase;
  logic                  cmd_valid;
  logic [2:0]            branch_done;
  logic [2:0]            branch_hs;
  logic                  fork_done;
  logic [SQ_ADDR_W-1:0]  sq_slot_addr;
  logic [MEM_ADDR_W-1:0] buf_slot_addr;

  assign tail_next = sq_tail + QIDX_W'(1);

  // hold off while the SQ is full or the slot's previous command is still open
  assign cmd_valid = host_awvalid & (tail_next != sq_head) & (cid_state[sq_tail] == cid_phase);

  // three way fork: SQ address, SQ entry, buffer address
  assign sq_awvalid  = cmd_valid & ~branch_done[0];
  assign sq_wvalid   = cmd_valid & ~branch_done[1];
  assign buf_awvalid = cmd_valid & ~branch_done[2];
  assign branch_hs = {buf_awvalid & buf_awready, sq_wvalid & sq_wready, sq_awvalid & sq_awready};
  assign fork_done = &(branch_hs | branch_done);

  assign host_awready = (cmd_valid & fork_done) | ~host_awvalid;

  assign sq_slot_addr  = SQ_ADDR_W'(sq_tail) << SQ_ENTRY_SHIFT;
  assign buf_slot_addr = MEM_ADDR_W'(sq_tail) << BUF_SLOT_SHIFT;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      sq_tail     <= '0;
      cid_phase   <= 1'b0;
      branch_done <= '0;
    end else begin
      if (host_awvalid && host_awready) begin
        sq_tail <= tail_next;
        // new lap over the command IDs
        if (sq_tail == QIDX_W'(QUEUE_DEPTH - 1)) begin
          cid_phase <= ~cid_phase;
        end
      end
      branch_done <= (cmd_valid & ~fork_done) ? (branch_done | branch_hs) : '0;
    end
  end

  always_comb begin
    // single 64 B beat into the tail slot
    sq_aw.addr  = HOST_ADDR_W'(sq_slot_addr);
    sq_aw.len   = 8'd0;
    sq_aw.size  = 3'(SQ_ENTRY_SHIFT);
    sq_aw.burst = AXI_BURST_INCR;

    // write command, one block per host burst
    sq_w        = '0;
    sq_w.opcode = NVME_OP_WRITE;
    sq_w.cid    = 16'(sq_tail);
    sq_w.nsid   = NSID_DEFAULT;
    sq_w.dptr   = 128'(WRITE_BUF_BASE + buf_slot_addr);
    sq_w.slba   = 64'(host_aw.addr >> BUF_SLOT_SHIFT);

    // host data lands in the slot owned by this command
    buf_aw      = host_aw;
    buf_aw.addr = HOST_ADDR_W'(buf_slot_addr);
  end

endmodule

`default_nettype wire

//--- logic/nvme_sq_doorbell.sv
`timescale 1ns/10ps
`default_nettype none

module nvme_sq_doorbell (
  input  logic                                clk,
  input  logic                                rstn,
  input  logic                                sq_bvalid,
  output logic                                sq_bready,
  input  logic                                buf_bvalid,
  output logic                                buf_bready,
  output nvme_wr_pkg::axi_addr_t              sqdb_aw,
  output logic                                sqdb_awvalid,
  input  logic                                sqdb_awready,
  output logic [nvme_wr_pkg::HOST_DATA_W-1:0] sqdb_wdata,
  output logic                                sqdb_wvalid,
  input  logic                                sqdb_wready
);
  import nvme_wr_pkg::*;

  logic [QIDX_W-1:0] db_tail;
  logic [QIDX_W-1:0] db_next;
  logic              join_valid;
  logic [1:0]        branch_done;
  logic [1:0]        branch_hs;
  logic              fork_done;

  // command is in memory once both the entry and its address slot are acked
  assign join_valid = sq_bvalid & buf_bvalid;

  assign sqdb_awvalid = join_valid & ~branch_done[0];
  assign sqdb_wvalid  = join_valid & ~branch_done[1];
  assign branch_hs = {sqdb_wvalid & sqdb_wready, sqdb_awvalid & sqdb_awready};
  assign fork_done = &(branch_hs | branch_done);

  assign sq_bready  = (join_valid & fork_done) | ~sq_bvalid;
  assign buf_bready = (join_valid & fork_done) | ~buf_bvalid;

  assign db_next = db_tail + QIDX_W'(1);

  assign sqdb_aw.addr  = HOST_ADDR_W'(SQ_TAIL_DB_ADDR);
  assign sqdb_aw.len   = 8'd0;
  assign sqdb_aw.size  = DB_XFER_SIZE;
  assign sqdb_aw.burst = AXI_BURST_INCR;

  // tail value sits in lane 2, doorbell offset is 8 within the beat
  assign sqdb_wdata = {32'd0, 32'(db_next), 64'd0};

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      db_tail     <= '0;
      branch_done <= '0;
    end else begin
      if (join_valid && fork_done) begin
        db_tail <= db_next;
      end
      branch_done <= (join_valid & ~fork_done) ? (branch_done | branch_hs) : '0;
    end
  end

endmodule

`default_nettype wire

//--- logic/nvme_cq_poller.sv
`timescale 1ns/10ps
`default_nettype none

module nvme_cq_poller (
  input  logic                                clk,
  input  logic                                rstn,
  input  logic                                sqdb_bvalid,
  output logic                                sqdb_bready,
  output nvme_wr_pkg::axi_addr_t              cq_ar,
  output logic                                cq_arvalid,
  input  logic                                cq_arready,
  input  nvme_wr_pkg::cq_entry_t              cq_r,
  input  logic                                cq_rvalid,
  output logic                                cq_rready,
  output nvme_wr_pkg::axi_addr_t              cqdb_aw,
  output logic                                cqdb_awvalid,
  input  logic                                cqdb_awready,
  output logic [nvme_wr_pkg::HOST_DATA_W-1:0] cqdb_wdata,
  output logic                                cqdb_wvalid,
  input  logic                                cqdb_wready,
  input  logic                                cqdb_bvalid,
  output logic                                cqdb_bready,
  output logic [nvme_wr_pkg::QIDX_W-1:0]      sq_head,
  output logic [nvme_wr_pkg::QUEUE_DEPTH-1:0] cid_state
);
  import nvme_wr_pkg::*;

  cq_poll_state_t    state;
  logic [QIDX_W-1:0] cq_head;
  logic              cq_phase;
  logic [QIDX_W-1:0] cq_cid;
  logic              fresh;
  logic              db_valid;
  logic              db_b_pending;
  logic [1:0]        db_done;
  logic [1:0]        db_hs;
  logic              db_fork_done;

  // controller inverts the phase tag on every pass through the CQ
  assign fresh  = cq_r.phase != cq_phase;
  assign cq_cid = cq_r.cid[QIDX_W-1:0];

  assign sqdb_bready = (state == CQ_IDLE);
  assign cq_arvalid  = (state == CQ_READ_ADDR);
  assign cq_rready   = (state == CQ_READ_DATA);

  // next head write waits for the previous head write to be acked
  assign db_valid     = (state == CQ_RING_DB) & ~db_b_pending;
  assign cqdb_awvalid = db_valid & ~db_done[0];
  assign cqdb_wvalid  = db_valid & ~db_done[1];
  assign db_hs = {cqdb_wvalid & cqdb_wready, cqdb_awvalid & cqdb_awready};
  assign db_fork_done = db_valid & (&(db_hs | db_done));
  assign cqdb_bready  = 1'b1;

  assign cq_ar.addr  = HOST_ADDR_W'(MEM_ADDR_W'(cq_head) << CQ_ENTRY_SHIFT);
  assign cq_ar.len   = 8'd0;
  assign cq_ar.size  = 3'(CQ_ENTRY_SHIFT);
  assign cq_ar.burst = AXI_BURST_INCR;

  assign cqdb_aw.addr  = HOST_ADDR_W'(CQ_HEAD_DB_ADDR);
  assign cqdb_aw.len   = 8'd0;
  assign cqdb_aw.size  = DB_XFER_SIZE;
  assign cqdb_aw.burst = AXI_BURST_INCR;

  // head value in lane 3, offset 'hc within the beat
  assign cqdb_wdata = {32'(cq_head), 96'd0};

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state        <= CQ_IDLE;
      cq_head      <= '0;
      cq_phase     <= 1'b0;
      sq_head      <= '0;
      cid_state    <= '0;
      db_done      <= '0;
      db_b_pending <= 1'b0;
    end else begin
      if (db_fork_done) begin
        db_b_pending <= 1'b1;
      end else if (cqdb_bvalid && cqdb_bready) begin
        db_b_pending <= 1'b0;
      end
      db_done <= (db_valid & ~db_fork_done) ? (db_done | db_hs) : '0;

      case (state)
        CQ_IDLE: begin
          if (sqdb_bvalid && sqdb_bready) begin
            state <= CQ_READ_ADDR;
          end
        end
        CQ_READ_ADDR: begin
          if (cq_arvalid && cq_arready) begin
            state <= CQ_READ_DATA;
          end
        end
        CQ_READ_DATA: begin
          if (cq_rvalid && cq_rready) begin
            if (fresh) begin
              state   <= CQ_RING_DB;
              cq_head <= cq_head + QIDX_W'(1);
              if (cq_head == QIDX_W'(QUEUE_DEPTH - 1)) begin
                cq_phase <= ~cq_phase;
              end
              sq_head           <= cq_r.sq_head[QIDX_W-1:0];
              // releases the slot and signals the response side
              cid_state[cq_cid] <= ~cid_state[cq_cid];
            end else begin
              // stale entry, poll the same slot again
              state <= CQ_READ_ADDR;
            end
          end
        end
        CQ_RING_DB: begin
          if (db_fork_done) begin
            state <= CQ_IDLE;
          end
        end
        default: begin
          state <= CQ_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- logic/nvme_wr_response.sv
`timescale 1ns/10ps
`default_nettype none

module nvme_wr_response (
  input  logic                                clk,
  input  logic                                rstn,
  input  logic [nvme_wr_pkg::QUEUE_DEPTH-1:0] cid_state,
  output logic                                host_bvalid,
  input  logic                                host_bready,
  output logic [1:0]                          host_bresp
);
  import nvme_wr_pkg::*;

  logic [QIDX_W-1:0] resp_idx;
  logic              resp_phase;
  logic [QIDX_W-1:0] idx_next;
  logic              phase_next;
  logic              resp_accept;

  assign resp_accept = host_bvalid & host_bready;
  assign idx_next    = resp_accept ? resp_idx + QIDX_W'(1) : resp_idx;
  assign phase_next  = (resp_accept && resp_idx == QIDX_W'(QUEUE_DEPTH - 1)) ?
                       ~resp_phase : resp_phase;

  // write completions report success only
  assign host_bresp = 2'b00;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      resp_idx    <= '0;
      resp_phase  <= 1'b0;
      host_bvalid <= 1'b0;
    end else begin
      resp_idx    <= idx_next;
      resp_phase  <= phase_next;
      // look ahead at the next index so responses can go back to back
      host_bvalid <= cid_state[idx_next] != phase_next;
    end
  end

endmodule

`default_nettype wire

//--- logic/nvme_wr_driver.sv
`timescale 1ns/10ps
`default_nettype none

module nvme_wr_driver (
  input  logic                                    clk,
  input  logic                                    rstn,
  // host write port
  input  nvme_wr_pkg::axi_addr_t                  host_aw,
  input  logic                                    host_awvalid,
  output logic                                    host_awready,
  input  logic [nvme_wr_pkg::HOST_DATA_W-1:0]     host_wdata,
  input  logic [nvme_wr_pkg::HOST_DATA_W/8-1:0]   host_wstrb,
  input  logic                                    host_wlast,
  input  logic                                    host_wvalid,
  output logic                                    host_wready,
  output logic                                    host_bvalid,
  input  logic                                    host_bready,
  output logic [1:0]                              host_bresp,
  // submission queue memory
  output nvme_wr_pkg::axi_addr_t                  sq_aw,
  output logic                                    sq_awvalid,
  input  logic                                    sq_awready,
  output nvme_wr_pkg::sq_entry_t                  sq_w,
  output logic                                    sq_wvalid,
  input  logic                                    sq_wready,
  input  logic                                    sq_bvalid,
  output logic                                    sq_bready,
  // write buffer memory
  output nvme_wr_pkg::axi_addr_t                  buf_aw,
  output logic                                    buf_awvalid,
  input  logic                                    buf_awready,
  output logic [nvme_wr_pkg::HOST_DATA_W-1:0]     buf_wdata,
  output logic [nvme_wr_pkg::HOST_DATA_W/8-1:0]   buf_wstrb,
  output logic                                    buf_wlast,
  output logic                                    buf_wvalid,
  input  logic                                    buf_wready,
  input  logic                                    buf_bvalid,
  output logic                                    buf_bready,
  // controller doorbells and completion queue
  output nvme_wr_pkg::axi_addr_t                  sqdb_aw,
  output logic                                    sqdb_awvalid,
  input  logic                                    sqdb_awready,
  output logic [nvme_wr_pkg::HOST_DATA_W-1:0]     sqdb_wdata,
  output logic                                    sqdb_wvalid,
  input  logic                                    sqdb_wready,
  input  logic                                    sqdb_bvalid,
  output logic                                    sqdb_bready,
  output nvme_wr_pkg::axi_addr_t                  cq_ar,
  output logic                                    cq_arvalid,
  input  logic                                    cq_arready,
  input  nvme_wr_pkg::cq_entry_t                  cq_r,
  input  logic                                    cq_rvalid,
  output logic                                    cq_rready,
  output nvme_wr_pkg::axi_addr_t                  cqdb_aw,
  output logic                                    cqdb_awvalid,
  input  logic                                    cqdb_awready,
  output logic [nvme_wr_pkg::HOST_DATA_W-1:0]     cqdb_wdata,
  output logic                                    cqdb_wvalid,
  input  logic                                    cqdb_wready,
  input  logic                                    cqdb_bvalid,
  output logic                                    cqdb_bready
);
  import nvme_wr_pkg::*;

  logic [QIDX_W-1:0]      sq_head;
  logic [QUEUE_DEPTH-1:0] cid_state;

  // host beats go straight into the slot opened by the submit side
  assign buf_wdata   = host_wdata;
  assign buf_wstrb   = host_wstrb;
  assign buf_wlast   = host_wlast;
  assign buf_wvalid  = host_wvalid;
  assign host_wready = buf_wready;

  nvme_sq_submit sq_submit_i (
    .clk, .rstn,
    .host_aw, .host_awvalid, .host_awready,
    .sq_aw, .sq_awvalid, .sq_awready,
    .sq_w, .sq_wvalid, .sq_wready,
    .buf_aw, .buf_awvalid, .buf_awready,
    .sq_head, .cid_state
  );

  nvme_sq_doorbell sq_doorbell_i (
    .clk, .rstn,
    .sq_bvalid, .sq_bready, .buf_bvalid, .buf_bready,
    .sqdb_aw, .sqdb_awvalid, .sqdb_awready,
    .sqdb_wdata, .sqdb_wvalid, .sqdb_wready
  );

  nvme_cq_poller cq_poller_i (
    .clk, .rstn,
    .sqdb_bvalid, .sqdb_bready,
    .cq_ar, .cq_arvalid, .cq_arready,
    .cq_r, .cq_rvalid, .cq_rready,
    .cqdb_aw, .cqdb_awvalid, .cqdb_awready,
    .cqdb_wdata, .cqdb_wvalid, .cqdb_wready,
    .cqdb_bvalid, .cqdb_bready,
    .sq_head, .cid_state
  );

  nvme_wr_response wr_response_i (
    .clk, .rstn,
    .cid_state, .host_bvalid, .host_bready, .host_bresp
  );

endmodule

`default_nettype wire

//--- sim/tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic rstn
);

  localparam int HALF_PERIOD_NS = 20;
  localparam int RESET_CYCLES = 16;

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD_NS) clk = ~clk;
  end

  // reset released on a rising edge
  initial begin
    rstn = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rstn <= 1'b1;
  end

endmodule

`default_nettype wire

//--- sim/nvme_wr_driver_tb.sv
`timescale 1ns/10ps
`default_nettype none

module nvme_wr_driver_tb;
  import nvme_wr_pkg::*;

  localparam int NUM_BURSTS = 300;
  localparam int CLK_PERIOD_NS = 40;
  localparam int WATCHDOG_NS = NUM_BURSTS * 400 * CLK_PERIOD_NS;
  localparam int NUM_TESTS = 6;
  localparam int T_SQ = 0;
  localparam int T_BUF = 1;
  localparam int T_SQDB = 2;
  localparam int T_CQ = 3;
  localparam int T_RESP = 4;
  localparam int T_LIMIT = 5;
  // 516 MiB
  localparam logic [31:0] BUF_BASE = 32'h2040_0000;

  typedef struct packed {
    logic         last;
    logic [15:0]  strb;
    logic [127:0] data;
  } beat_t;

  logic clk, rstn;
  axi_addr_t host_aw, sq_aw, buf_aw, sqdb_aw, cq_ar, cqdb_aw;
  sq_entry_t sq_w;
  cq_entry_t cq_r;
  logic host_awvalid, host_awready, host_wlast, host_wvalid, host_wready;
  logic [127:0] host_wdata, buf_wdata, sqdb_wdata, cqdb_wdata;
  logic [15:0] host_wstrb, buf_wstrb;
  logic host_bvalid, host_bready;
  logic [1:0] host_bresp;
  logic sq_awvalid, sq_awready, sq_wvalid, sq_wready, sq_bvalid, sq_bready;
  logic buf_awvalid, buf_awready, buf_wlast, buf_wvalid, buf_wready, buf_bvalid, buf_bready;
  logic sqdb_awvalid, sqdb_awready, sqdb_wvalid, sqdb_wready, sqdb_bvalid, sqdb_bready;
  logic cq_arvalid, cq_arready, cq_rvalid, cq_rready;
  logic cqdb_awvalid, cqdb_awready, cqdb_wvalid, cqdb_wready, cqdb_bvalid, cqdb_bready;

  integer seed;
  int checks [NUM_TESTS];
  int errors [NUM_TESTS];
  string test_name [NUM_TESTS];
  logic [HOST_ADDR_W-1:0] burst_addr [NUM_BURSTS];
  logic [7:0] burst_len [NUM_BURSTS];
  beat_t host_beats[$];
  beat_t exp_beats[$];
  logic [3:0] pend_cid[$];
  cq_entry_t cq_mem [QUEUE_DEPTH];

  int aw_sent, aw_acc, resp_cnt, sq_aw_cnt, sq_w_cnt, sq_b_sent;
  int buf_aw_cnt, wlast_cnt, buf_b_sent;
  int sqdb_aw_cnt, sqdb_w_cnt, sqdb_b_sent, cqdb_aw_cnt, cqdb_w_cnt, cqdb_b_sent;
  int posted_cnt, returned_cnt, total_checks, total_errors;
  logic [3:0] ctrl_tail, ctrl_cq_tail;
  logic ctrl_phase, r_fresh;
  logic [31:0] rnd_hi, rnd_lo;

  tb_clock_gen clock_gen_i (.clk(clk), .rstn(rstn));

  nvme_wr_driver dut_i (.*);

  function automatic int min_count(input int a, input int b);
    return (a < b) ? a : b;
  endfunction

  // one beat, incrementing burst
  function automatic axi_addr_t single_beat(input logic [47:0] addr, input logic [2:0] size);
    axi_addr_t aw;
    aw.addr  = addr;
    aw.len   = 8'd0;
    aw.size  = size;
    aw.burst = 2'b01;
    return aw;
  endfunction

  task automatic check_value(input int test_id, input string name,
                             input logic [511:0] got, input logic [511:0] exp);
    checks[test_id]++;
    if (got !== exp) begin
      errors[test_id]++;
      $display("[ERROR] %0t ns %s: got 'h%0h expected 'h%0h", $time, name, got, exp);
    end
  endtask

  task drive_host();
    int in_flight;
    beat_t beat;
    if (host_awvalid && host_awready) begin
      in_flight = aw_acc + 1 - returned_cnt;
      check_value(T_LIMIT, "in_flight_over_15", 512'(in_flight > 15), 512'(0));
      aw_acc++;
    end
    // valid holds until the address is taken
    if (!host_awvalid || host_awready) begin
      if (aw_sent < NUM_BURSTS && ($random(seed) & 3) != 0) begin
        host_aw <= '{addr: burst_addr[aw_sent], len: burst_len[aw_sent],
                     size: 3'd4, burst: 2'b01};
        host_awvalid <= 1'b1;
        aw_sent++;
      end else begin
        host_awvalid <= 1'b0;
      end
    end
    if (!host_wvalid || host_wready) begin
      if (host_beats.size() > 0 && ($random(seed) & 3) != 0) begin
        beat = host_beats.pop_front();
        host_wdata  <= beat.data;
        host_wstrb  <= beat.strb;
        host_wlast  <= beat.last;
        host_wvalid <= 1'b1;
      end else begin
        host_wvalid <= 1'b0;
      end
    end
    if (host_bvalid && host_bready) begin
      check_value(T_RESP, "host_bresp", 512'(host_bresp), 512'(0));
      check_value(T_RESP, "resp_before_completion", 512'(resp_cnt < returned_cnt), 512'(1));
      resp_cnt++;
    end
    host_bready <= (($random(seed) & 3) != 0);
  endtask

  task serve_queue_memory();
    int slot;
    sq_entry_t exp_entry;
    axi_addr_t exp_aw;
    beat_t beat;
    if (sq_awvalid && sq_awready) begin
      slot = sq_aw_cnt % QUEUE_DEPTH;
      check_value(T_SQ, "sq_aw", 512'(sq_aw), 512'(single_beat(48'(slot * 64), 3'd6)));
      sq_aw_cnt++;
    end
    if (sq_wvalid && sq_wready) begin
      slot = sq_w_cnt % QUEUE_DEPTH;
      exp_entry        = '0;
      exp_entry.opcode = nvme_opcode_t'(8'h01);
      exp_entry.cid    = 16'(slot);
      exp_entry.nsid   = 32'd1;
      exp_entry.dptr   = 128'(BUF_BASE) + 128'(slot * 4096);
      exp_entry.slba   = 64'(burst_addr[sq_w_cnt] >> 12);
      check_value(T_SQ, "sq_w", sq_w, exp_entry);
      sq_w_cnt++;
    end
    if (buf_awvalid && buf_awready) begin
      exp_aw.addr  = 48'((buf_aw_cnt % QUEUE_DEPTH) * 4096);
      exp_aw.len   = burst_len[buf_aw_cnt];
      exp_aw.size  = 3'd4;
      exp_aw.burst = 2'b01;
      check_value(T_BUF, "buf_aw", 512'(buf_aw), 512'(exp_aw));
      buf_aw_cnt++;
    end
    if (buf_wvalid && buf_wready) begin
      if (exp_beats.size() == 0) begin
        errors[T_BUF]++;
        $display("buffer data beat arrived with no host beat left to match it");
      end else begin
        beat = exp_beats.pop_front();
        check_value(T_BUF, "buf_wdata", 512'(buf_wdata), 512'(beat.data));
        check_value(T_BUF, "buf_wstrb", 512'(buf_wstrb), 512'(beat.strb));
        check_value(T_BUF, "buf_wlast", 512'(buf_wlast), 512'(beat.last));
      end
      if (buf_wlast) begin
        wlast_cnt++;
      end
    end
    if (sq_bvalid && sq_bready) begin
      sq_b_sent++;
    end
    if (buf_bvalid && buf_bready) begin
      buf_b_sent++;
    end
    sq_bvalid   <= min_count(sq_aw_cnt, sq_w_cnt) > sq_b_sent;
    buf_bvalid  <= min_count(buf_aw_cnt, wlast_cnt) > buf_b_sent;
    sq_awready  <= 1'($random(seed));
    sq_wready   <= 1'($random(seed));
    buf_awready <= 1'($random(seed));
    buf_wready  <= 1'($random(seed));
  endtask

  task serve_doorbells();
    logic [127:0] exp_db;
    logic [3:0] new_tail;
    if (sqdb_awvalid && sqdb_awready) begin
      check_value(T_SQDB, "sqdb_aw", 512'(sqdb_aw), 512'(single_beat(48'h1008, 3'd2)));
      sqdb_aw_cnt++;
    end
    if (sqdb_wvalid && sqdb_wready) begin
      exp_db = {32'd0, 28'd0, 4'(sqdb_w_cnt + 1), 64'd0};
      check_value(T_SQDB, "sqdb_wdata", 512'(sqdb_wdata), 512'(exp_db));
      // controller fetches every slot up to the new tail
      new_tail = sqdb_wdata[67:64];
      while (ctrl_tail != new_tail) begin
        pend_cid.push_back(ctrl_tail);
        ctrl_tail = ctrl_tail + 4'd1;
      end
      sqdb_w_cnt++;
    end
    if (cqdb_awvalid && cqdb_awready) begin
      check_value(T_CQ, "cqdb_aw", 512'(cqdb_aw), 512'(single_beat(48'h100c, 3'd2)));
      cqdb_aw_cnt++;
    end
    if (cqdb_wvalid && cqdb_wready) begin
      exp_db = {28'd0, 4'(cqdb_w_cnt + 1), 96'd0};
      check_value(T_CQ, "cqdb_wdata", 512'(cqdb_wdata), 512'(exp_db));
      check_value(T_CQ, "fresh_entries_at_cqdb", 512'(returned_cnt), 512'(cqdb_w_cnt + 1));
      cqdb_w_cnt++;
    end
    if (sqdb_bvalid && sqdb_bready) begin
      sqdb_b_sent++;
    end
    if (cqdb_bvalid && cqdb_bready) begin
      cqdb_b_sent++;
    end
    sqdb_bvalid  <= min_count(sqdb_aw_cnt, sqdb_w_cnt) > sqdb_b_sent;
    cqdb_bvalid  <= min_count(cqdb_aw_cnt, cqdb_w_cnt) > cqdb_b_sent;
    sqdb_awready <= 1'($random(seed));
    sqdb_wready  <= 1'($random(seed));
    cqdb_awready <= 1'($random(seed));
    cqdb_wready  <= 1'($random(seed));
  endtask

  task serve_completion_queue();
    cq_entry_t entry;
    logic [3:0] cid;
    logic [3:0] head_after;
    if (cq_rvalid && cq_rready) begin
      cq_rvalid <= 1'b0;
      if (r_fresh) begin
        returned_cnt++;
      end
    end
    if (cq_arvalid && cq_arready) begin
      // head advances once per fresh entry taken
      check_value(T_CQ, "cq_ar", 512'(cq_ar),
                  512'(single_beat(48'((returned_cnt % QUEUE_DEPTH) * 16), 3'd4)));
      cq_r      <= cq_mem[cq_ar.addr[7:4]];
      cq_rvalid <= 1'b1;
      // stale when nothing new was posted at the head
      r_fresh = posted_cnt > returned_cnt;
    end
    // completions trail the doorbell by a random delay
    if (pend_cid.size() > 0 && ($random(seed) & 7) == 0) begin
      cid = pend_cid.pop_front();
      head_after = cid + 4'd1;
      entry         = '0;
      entry.cid     = 16'(cid);
      entry.sq_head = 16'(head_after);
      entry.sq_id   = 16'd1;
      entry.phase   = ctrl_phase;
      cq_mem[ctrl_cq_tail] = entry;
      ctrl_cq_tail = ctrl_cq_tail + 4'd1;
      if (ctrl_cq_tail == 4'd0) begin
        ctrl_phase = ~ctrl_phase;
      end
      posted_cnt++;
    end
    cq_arready <= 1'($random(seed));
  endtask

  always @(posedge clk) begin
    if (rstn) begin
      drive_host();
      serve_queue_memory();
      serve_doorbells();
      serve_completion_queue();
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout after %0d ns with %0d of %0d host write responses",
             WATCHDOG_NS, resp_cnt, NUM_BURSTS);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    beat_t beat;
    seed = 32'h2300b769;
    test_name[T_SQ]    = "sq entry writes";
    test_name[T_BUF]   = "buffer address and data";
    test_name[T_SQDB]  = "sq tail doorbell";
    test_name[T_CQ]    = "cq polling and head doorbell";
    test_name[T_RESP]  = "host write responses";
    test_name[T_LIMIT] = "commands in flight";
    for (int t = 0; t < NUM_TESTS; t++) begin
      checks[t] = 0;
      errors[t] = 0;
    end
    host_aw = '0;
    host_awvalid = 1'b0;
    host_wdata = '0;
    host_wstrb = '0;
    host_wlast = 1'b0;
    host_wvalid = 1'b0;
    host_bready = 1'b0;
    sq_awready = 1'b0;
    sq_wready = 1'b0;
    sq_bvalid = 1'b0;
    buf_awready = 1'b0;
    buf_wready = 1'b0;
    buf_bvalid = 1'b0;
    sqdb_awready = 1'b0;
    sqdb_wready = 1'b0;
    sqdb_bvalid = 1'b0;
    cq_arready = 1'b0;
    cq_r = '0;
    cq_rvalid = 1'b0;
    cqdb_awready = 1'b0;
    cqdb_wready = 1'b0;
    cqdb_bvalid = 1'b0;
    aw_sent = 0;
    aw_acc = 0;
    resp_cnt = 0;
    sq_aw_cnt = 0;
    sq_w_cnt = 0;
    sq_b_sent = 0;
    buf_aw_cnt = 0;
    wlast_cnt = 0;
    buf_b_sent = 0;
    sqdb_aw_cnt = 0;
    sqdb_w_cnt = 0;
    sqdb_b_sent = 0;
    cqdb_aw_cnt = 0;
    cqdb_w_cnt = 0;
    cqdb_b_sent = 0;
    posted_cnt = 0;
    returned_cnt = 0;
    ctrl_tail = '0;
    ctrl_cq_tail = '0;
    // first pass of the CQ carries phase 1
    ctrl_phase = 1'b1;
    r_fresh = 1'b0;
    for (int i = 0; i < QUEUE_DEPTH; i++) begin
      cq_mem[i] = '0;
    end

    // host bursts of one to four beats
    for (int i = 0; i < NUM_BURSTS; i++) begin
      rnd_hi = $random(seed);
      rnd_lo = $random(seed);
      burst_addr[i] = {rnd_hi[15:0], rnd_lo};
      burst_len[i] = 8'($random(seed) & 3);
      for (int b = 0; b <= int'(burst_len[i]); b++) begin
        for (int w = 0; w < 4; w++) begin
          beat.data[w*32 +: 32] = $random(seed);
        end
        beat.strb = 16'($random(seed));
        beat.last = (b == int'(burst_len[i]));
        host_beats.push_back(beat);
        exp_beats.push_back(beat);
      end
    end

    wait (rstn === 1'b1);
    while (resp_cnt < NUM_BURSTS) begin
      @(negedge clk);
    end
    // quiet time to catch late or duplicated responses
    repeat (50) @(negedge clk);

    check_value(T_SQ, "sq_w_count", 512'(sq_w_cnt), 512'(NUM_BURSTS));
    check_value(T_BUF, "buf_aw_count", 512'(buf_aw_cnt), 512'(NUM_BURSTS));
    check_value(T_BUF, "beats_left", 512'(exp_beats.size()), 512'(0));
    check_value(T_SQDB, "sqdb_w_count", 512'(sqdb_w_cnt), 512'(NUM_BURSTS));
    check_value(T_CQ, "fresh_entries", 512'(returned_cnt), 512'(NUM_BURSTS));
    check_value(T_CQ, "cqdb_w_count", 512'(cqdb_w_cnt), 512'(NUM_BURSTS));
    check_value(T_RESP, "host_b_count", 512'(resp_cnt), 512'(posted_cnt));
    check_value(T_LIMIT, "host_aw_count", 512'(aw_acc), 512'(NUM_BURSTS));

    total_checks = 0;
    total_errors = 0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      $display("test %0d %s: %0d checks, %0d errors", t, test_name[t], checks[t], errors[t]);
      total_checks += checks[t];
      total_errors += errors[t];
    end
    $display("%0d bursts, %0d checks, %0d errors", NUM_BURSTS, total_checks, total_errors);
    if (total_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- nvme_wr_driver.f
logic/nvme_wr_pkg.sv
logic/nvme_sq_submit.sv
logic/nvme_sq_doorbell.sv
logic/nvme_cq_poller.sv
logic/nvme_wr_response.sv
logic/nvme_wr_driver.sv
sim/tb_clock_gen.sv
sim/nvme_wr_driver_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the NVMe write path testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps \
  --top-module nvme_wr_driver_tb \
  -f nvme_wr_driver.f \
  --Mdir obj_dir

./obj_dir/Vnvme_wr_driver_tb | tee sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
  exit 1
fi
exit 0
